// ==== design/soc_pkg.sv ====
package soc_pkg;

  // Bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 16;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Peripheral region, taken from address bits 15 to 12
  typedef enum logic [3:0] {
    REG_RAM  = 4'h0,
    REG_UART = 4'h8,
    REG_ENC  = 4'h9,
    REG_HEX  = 4'hA,
    REG_NONE = 4'hF
  } region_e;

  // Encoder counts 0 to ENC_STEPS-1
  localparam int ENC_STEPS = 24;

endpackage

// ==== design/periph_bus_if.sv ====
`timescale 1ns/1ps

interface periph_bus_if;
  import soc_pkg::*;

  logic  sel;
  logic  write;
  addr_t addr;
  data_t wdata;
  data_t rdata;

  // Decoder side
  modport fabric (output sel, output write, output addr, output wdata, input rdata);

  // Peripheral side
  modport periph (input sel, input write, input addr, input wdata, output rdata);

endinterface

// ==== design/bus_decode.sv ====
`timescale 1ns/1ps

module bus_decode (
  input  soc_pkg::addr_t addr,
  input  soc_pkg::data_t wdata,
  input  logic           write,
  output soc_pkg::data_t rdata,
  periph_bus_if.fabric   ram,
  periph_bus_if.fabric   uart,
  periph_bus_if.fabric   enc,
  periph_bus_if.fabric   hex
);
  import soc_pkg::*;

  region_e region;

  // Unmapped regions fold into REG_NONE
  always_comb begin
    case (addr[15:12])
      4'h0:    region = REG_RAM;
      4'h8:    region = REG_UART;
      4'h9:    region = REG_ENC;
      4'hA:    region = REG_HEX;
      default: region = REG_NONE;
    endcase
  end

  assign ram.sel  = (region == REG_RAM);
  assign uart.sel = (region == REG_UART);
  assign enc.sel  = (region == REG_ENC);
  assign hex.sel  = (region == REG_HEX);

  // Shared write side
  assign ram.addr   = addr;
  assign ram.wdata  = wdata;
  assign ram.write  = write;
  assign uart.addr  = addr;
  assign uart.wdata = wdata;
  assign uart.write = write;
  assign enc.addr   = addr;
  assign enc.wdata  = wdata;
  assign enc.write  = write;
  assign hex.addr   = addr;
  assign hex.wdata  = wdata;
  assign hex.write  = write;

  // Deselected peripherals return zero, so a plain OR is enough
  assign rdata = ram.rdata | uart.rdata | enc.rdata | hex.rdata;

endmodule

// ==== design/scratch_ram.sv ====
`timescale 1ns/1ps

module scratch_ram #(
  parameter int RAM_WORDS = 256
) (
  input logic          clk,
  input logic          rst_n,
  periph_bus_if.periph bus
);
  import soc_pkg::*;

  localparam int AW = $clog2(RAM_WORDS);

  data_t          mem [RAM_WORDS];
  logic  [AW-1:0] word_addr;

  // Byte addressable bus, word wide memory
  assign word_addr = bus.addr[AW:1];

  always_ff @(posedge clk) begin
    if (bus.sel && bus.write) begin
      mem[word_addr] <= bus.wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus.rdata <= '0;
    end else begin
      bus.rdata <= bus.sel ? mem[word_addr] : '0;
    end
  end

endmodule

// ==== design/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic         clk,
  input  logic         rst_n,
  periph_bus_if.periph bus,
  output logic         tx
);

  localparam int BAUD_W = $clog2(CLKS_PER_BIT);

  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } state_e;

  state_e            state;
  logic [BAUD_W-1:0] baud_cnt;
  logic [2:0]        bit_cnt;
  logic [7:0]        tx_byte;
  logic [1:0]        offset;
  logic              busy;
  logic              baud_end;
  logic              load;

  assign offset   = bus.addr[2:1];
  assign busy     = (state != IDLE);
  assign baud_end = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));
  // Writes while busy are dropped
  assign load     = bus.sel && bus.write && (offset == 2'd0) && !busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx_byte  <= '0;
      tx       <= 1'b1;
    end else begin
      case (state)
        IDLE: begin
          tx <= 1'b1;
          if (load) begin
            tx_byte  <= bus.wdata[7:0];
            baud_cnt <= '0;
            state    <= START;
            tx       <= 1'b0;
          end
        end
        START: begin
          if (baud_end) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state    <= DATA;
            tx       <= tx_byte[0];
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        DATA: begin
          if (baud_end) begin
            baud_cnt <= '0;
            if (bit_cnt == 3'd7) begin
              state <= STOP;
              tx    <= 1'b1;
            end else begin
              // LSB first
              bit_cnt <= bit_cnt + 3'd1;
              tx      <= tx_byte[bit_cnt + 3'd1];
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        STOP: begin
          if (baud_end) begin
            baud_cnt <= '0;
            state    <= IDLE;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Offset 0 is the last byte sent, offset 1 the status
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus.rdata <= '0;
    end else if (!bus.sel) begin
      bus.rdata <= '0;
    end else begin
      case (offset)
        2'd0:    bus.rdata <= {8'h00, tx_byte};
        2'd1:    bus.rdata <= {15'h0000, busy};
        default: bus.rdata <= '0;
      endcase
    end
  end

endmodule

// ==== design/quad_encoder.sv ====
`timescale 1ns/1ps

module quad_encoder (
  input  logic         clk,
  input  logic         rst_n,
  periph_bus_if.periph bus,
  input  logic [1:0]   quad,
  input  logic         pb,
  output logic [2:0]   rgb
);
  import soc_pkg::*;

  localparam int CNT_W = $clog2(ENC_STEPS);

  logic [2:0]       sync_meta;
  logic [2:0]       sync_q;
  logic [1:0]       quad_prev;
  logic [CNT_W-1:0] count;
  logic [1:0]       offset;
  logic             step_up;
  logic             step_dn;
  logic             load;

  assign offset = bus.addr[2:1];
  assign load   = bus.sel && bus.write && (offset == 2'd0);

  // Two-flop synchronizer for {pb, quad}, then one more stage for the edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_meta <= '0;
      sync_q    <= '0;
      quad_prev <= '0;
    end else begin
      sync_meta <= {pb, quad};
      sync_q    <= sync_meta;
      quad_prev <= sync_q[1:0];
    end
  end

  // Gray sequence 00 01 11 10 is forward, double jumps fall to default
  always_comb begin
    step_up = 1'b0;
    step_dn = 1'b0;
    case ({quad_prev, sync_q[1:0]})
      4'b0001, 4'b0111, 4'b1110, 4'b1000: step_up = 1'b1;
      4'b0100, 4'b1101, 4'b1011, 4'b0010: step_dn = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (load) begin
      // Out-of-range loads are ignored
      if (bus.wdata < data_t'(ENC_STEPS)) begin
        count <= bus.wdata[CNT_W-1:0];
      end
    end else if (step_up) begin
      count <= (count == CNT_W'(ENC_STEPS - 1)) ? '0 : count + 1'b1;
    end else if (step_dn) begin
      count <= (count == '0) ? CNT_W'(ENC_STEPS - 1) : count - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus.rdata <= '0;
    end else if (!bus.sel) begin
      bus.rdata <= '0;
    end else begin
      case (offset)
        2'd0:    bus.rdata <= data_t'(count);
        2'd1:    bus.rdata <= data_t'(sync_q[2]);
        default: bus.rdata <= '0;
      endcase
    end
  end

  // One colour per third of the range
  always_comb begin
    if (count < CNT_W'(8)) begin
      rgb = 3'b001;
    end else if (count < CNT_W'(16)) begin
      rgb = 3'b010;
    end else begin
      rgb = 3'b100;
    end
  end

endmodule

// ==== design/hex_display.sv ====
`timescale 1ns/1ps

module hex_display (
  input  logic         clk,
  input  logic         rst_n,
  periph_bus_if.periph bus,
  output logic [6:0]   hex0,
  output logic [6:0]   hex1,
  output logic [6:0]   hex2,
  output logic [6:0]   hex3
);
  import soc_pkg::*;

  data_t value;
  logic  at_reg;

  // Active low, bit 6 is segment g
  function automatic logic [6:0] seg7(input logic [3:0] nib);
    case (nib)
      4'h0: seg7 = 7'h40;
      4'h1: seg7 = 7'h79;
      4'h2: seg7 = 7'h24;
      4'h3: seg7 = 7'h30;
      4'h4: seg7 = 7'h19;
      4'h5: seg7 = 7'h12;
      4'h6: seg7 = 7'h02;
      4'h7: seg7 = 7'h78;
      4'h8: seg7 = 7'h00;
      4'h9: seg7 = 7'h10;
      4'hA: seg7 = 7'h08;
      4'hB: seg7 = 7'h03;
      4'hC: seg7 = 7'h46;
      4'hD: seg7 = 7'h21;
      4'hE: seg7 = 7'h06;
      default: seg7 = 7'h0E;
    endcase
  endfunction

  assign at_reg = bus.sel && (bus.addr[2:1] == 2'd0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      value     <= '0;
      bus.rdata <= '0;
    end else begin
      if (at_reg && bus.write) begin
        value <= bus.wdata;
      end
      bus.rdata <= at_reg ? value : '0;
    end
  end

  assign hex0 = seg7(value[3:0]);
  assign hex1 = seg7(value[7:4]);
  assign hex2 = seg7(value[11:8]);
  assign hex3 = seg7(value[15:12]);

endmodule

// ==== design/soc_top.sv ====
`timescale 1ns/1ps

module soc_top #(
  parameter int CLKS_PER_BIT = 434,
  parameter int RAM_WORDS    = 256
) (
  input  logic           clock_50,
  input  logic           rst_n,
  input  soc_pkg::addr_t bus_addr,
  input  soc_pkg::data_t bus_wdata,
  input  logic           bus_write,
  output soc_pkg::data_t bus_rdata,
  input  logic [1:0]     quad,
  input  logic           pb,
  output logic           serial_tx,
  output logic [2:0]     rgb,
  output logic [6:0]     hex0,
  output logic [6:0]     hex1,
  output logic [6:0]     hex2,
  output logic [6:0]     hex3
);

  // One bus per peripheral
  periph_bus_if ram_bus ();
  periph_bus_if uart_bus ();
  periph_bus_if enc_bus ();
  periph_bus_if hex_bus ();

  // Chip select and read mux
  bus_decode decode_i (
    .addr  (bus_addr),
    .wdata (bus_wdata),
    .write (bus_write),
    .rdata (bus_rdata),
    .ram   (ram_bus.fabric),
    .uart  (uart_bus.fabric),
    .enc   (enc_bus.fabric),
    .hex   (hex_bus.fabric)
  );

  scratch_ram #(.RAM_WORDS(RAM_WORDS)) ram_i (
    .clk   (clock_50),
    .rst_n (rst_n),
    .bus   (ram_bus.periph)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_i (
    .clk   (clock_50),
    .rst_n (rst_n),
    .bus   (uart_bus.periph),
    .tx    (serial_tx)
  );

  // Encoder with RGB indicator
  quad_encoder enc_i (
    .clk   (clock_50),
    .rst_n (rst_n),
    .bus   (enc_bus.periph),
    .quad  (quad),
    .pb    (pb),
    .rgb   (rgb)
  );

  hex_display hex_i (
    .clk   (clock_50),
    .rst_n (rst_n),
    .bus   (hex_bus.periph),
    .hex0  (hex0),
    .hex1  (hex1),
    .hex2  (hex2),
    .hex3  (hex3)
  );

endmodule

// ==== tests/soc_top_chk.sv ====
`timescale 1ns/1ps

module soc_top_chk (
  input logic       clk,
  input logic       rst_n,
  input logic       bus_write,
  input logic       serial_tx,
  input logic       uart_busy,
  input logic [2:0] rgb,
  input logic [3:0] sel
);

  int unsigned fails = 0;

  // Write strobe is a single-cycle pulse
  write_pulse: assert property (@(posedge clk) disable iff (!rst_n) bus_write |=> !bus_write)
    else begin
      $error("bus_write held high for two cycles");
      fails++;
    end

  idle_line: assert property (@(posedge clk) disable iff (!rst_n) !uart_busy |-> serial_tx)
    else begin
      $error("serial_tx low while the UART is idle");
      fails++;
    end

  rgb_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(rgb))
    else begin
      $error("rgb is not one-hot");
      fails++;
    end

  // Unmapped regions leave every select low
  sel_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(sel))
    else begin
      $error("more than one chip select high");
      fails++;
    end

endmodule

// ==== tests/soc_top_tb.sv ====
`timescale 1ns/1ps

module soc_top_tb;

  localparam int    CLKS_PER_BIT = 8;
  localparam int    CLK_PERIOD   = 4;
  localparam string TEST_FILE    = "tests/soc_top_tests.txt";

  logic        clock_50;
  logic        rst_n;
  logic [15:0] bus_addr;
  logic [15:0] bus_wdata;
  logic        bus_write;
  logic [15:0] bus_rdata;
  logic [1:0]  quad;
  logic        pb;
  logic        serial_tx;
  logic [2:0]  rgb;
  logic [6:0]  hex0;
  logic [6:0]  hex1;
  logic [6:0]  hex2;
  logic [6:0]  hex3;

  int unsigned    errors = 0;
  int unsigned    checks = 0;
  int unsigned    cycle = 0;
  int unsigned    limit = 0;
  int unsigned    fall_count = 0;
  int unsigned    frames_done = 0;
  int unsigned    n_lines = 0;
  int unsigned    n_uart = 0;
  int unsigned    assert_fails;
  time            fall_time = 0;
  int             fd;
  bit             ok;
  bit             hex_written = 0;
  logic [63:0]    tok;
  logic [7:0]     op;
  logic [8*32-1:0] name;
  logic [31:0]    fa;
  logic [31:0]    fb;

  soc_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) soc_top_i (
    .clock_50  (clock_50),
    .rst_n     (rst_n),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_write (bus_write),
    .bus_rdata (bus_rdata),
    .quad      (quad),
    .pb        (pb),
    .serial_tx (serial_tx),
    .rgb       (rgb),
    .hex0      (hex0),
    .hex1      (hex1),
    .hex2      (hex2),
    .hex3      (hex3)
  );

  bind soc_top soc_top_chk chk_i (
    .clk       (clock_50),
    .rst_n     (rst_n),
    .bus_write (bus_write),
    .serial_tx (serial_tx),
    .uart_busy (uart_i.busy),
    .rgb       (rgb),
    .sel       ({ram_bus.sel, uart_bus.sel, enc_bus.sel, hex_bus.sel})
  );

  always #(CLK_PERIOD / 2) clock_50 = ~clock_50;

  // Start of every UART frame
  always @(negedge serial_tx) begin
    fall_time  = $time;
    fall_count = fall_count + 1;
  end

  always @(posedge clock_50) begin
    cycle <= cycle + 1;
    if (limit != 0 && cycle >= limit) begin
      $display("Timeout: run did not finish within %0d cycles", limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // Expected indicator colour for a count, one third of the range each
  function automatic logic [2:0] rgb_for(input logic [15:0] count);
    if (count < 16'd8) begin
      return 3'b001;
    end else if (count < 16'd16) begin
      return 3'b010;
    end
    return 3'b100;
  endfunction

  // Skips comment lines, returns one record in op, name, fa and fb
  task automatic next_record(output bit found);
    int               code;
    bit               done;
    logic [8*128-1:0] rest;
    found = 0;
    done  = 0;
    while (!found && !done) begin
      code = $fscanf(fd, " %s", tok);
      if (code != 1) begin
        done = 1;
      end else if (tok == "#") begin
        code = $fgets(rest, fd);
      end else begin
        op   = tok[7:0];
        code = $fscanf(fd, " %s %h %h", name, fa, fb);
        if (code == 3) begin
          found = 1;
        end else begin
          errors++;
          $display("Malformed line in test file after operation %0s", op);
          done = 1;
        end
      end
    end
  endtask

  task automatic write_word(input logic [15:0] addr, input logic [15:0] data);
    @(posedge clock_50);
    bus_addr  <= addr;
    bus_wdata <= data;
    bus_write <= 1'b1;
    @(posedge clock_50);
    bus_write <= 1'b0;
    if (addr[15:12] == 4'hA) begin
      hex_written = 1'b1;
    end
  endtask

  task automatic read_check(input logic [15:0] addr, input logic [15:0] exp);
    @(posedge clock_50);
    bus_addr <= addr;
    @(posedge clock_50);
    @(negedge clock_50);
    checks++;
    assert (bus_rdata === exp) else begin
      errors++;
      $display("Error %0s: expected %04h, actual %04h", name, exp, bus_rdata);
    end
    // Encoder count reads also check the indicator
    if (addr[15:12] == 4'h9 && addr[2:1] == 2'd0) begin
      checks++;
      assert (rgb === rgb_for(exp)) else begin
        errors++;
        $display("Error %0s rgb: expected %03b, actual %03b", name, rgb_for(exp), rgb);
      end
    end
  endtask

  // Count moves three cycles after the input changes
  task automatic quad_step(input logic [1:0] q, input logic p);
    @(posedge clock_50);
    quad <= q;
    pb   <= p;
    repeat (3) @(posedge clock_50);
  endtask

  task automatic uart_frame_check(input logic [7:0] exp);
    logic [9:0]  frame;
    logic [9:0]  want;
    time         t0;
    int unsigned falls_before;
    int          i;
    while (fall_count == frames_done) @(negedge clock_50);
    frames_done++;
    t0   = fall_time;
    want = {1'b1, exp, 1'b0};
    for (i = 0; i < 10; i++) begin
      do @(negedge clock_50);
      while ($time < t0 + CLK_PERIOD * (CLKS_PER_BIT * i + CLKS_PER_BIT / 2));
      frame[i] = serial_tx;
    end
    checks++;
    assert (frame === want) else begin
      errors++;
      $display("Error %0s: expected %03h, actual %03h", name, want, frame);
    end
    falls_before = fall_count;
    repeat (2 * CLKS_PER_BIT) @(negedge clock_50);
    checks++;
    assert (fall_count == falls_before) else begin
      errors++;
      $display("%0s: a second frame started after the ignored write", name);
    end
  endtask

  task automatic hex_check(input logic [1:0] digit, input logic [6:0] exp);
    logic [6:0] seg;
    @(negedge clock_50);
    case (digit)
      2'd0:    seg = hex0;
      2'd1:    seg = hex1;
      2'd2:    seg = hex2;
      default: seg = hex3;
    endcase
    checks++;
    assert (seg === exp) else begin
      errors++;
      $display("Error %0s: expected %02h, actual %02h", name, exp, seg);
    end
    // Register still at reset, so every digit shows the same zero pattern
    if (!hex_written) begin
      checks++;
      assert ({hex3, hex2, hex1, hex0} === {4{exp}}) else begin
        errors++;
        $display("Error %0s all digits: expected %07h, actual %07h",
                 name, {4{exp}}, {hex3, hex2, hex1, hex0});
      end
    end
  endtask

  initial begin
    clock_50  = 1'b0;
    rst_n     = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    bus_write = 1'b0;
    quad      = 2'b00;
    pb        = 1'b0;

    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open test file %0s", TEST_FILE);
    end else begin
      // First pass sizes the cycle budget
      next_record(ok);
      while (ok) begin
        n_lines++;
        if (op == "U") begin
          n_uart++;
        end
        next_record(ok);
      end
      $fclose(fd);
      limit = 2 * (4 * n_lines + 100 * n_uart);
      fd    = $fopen(TEST_FILE, "r");
    end

    repeat (3) @(posedge clock_50);
    rst_n <= 1'b1;

    if (fd != 0) begin
      next_record(ok);
      while (ok) begin
        case (op)
          "W":     write_word(fa[15:0], fb[15:0]);
          "R":     read_check(fa[15:0], fb[15:0]);
          "Q":     quad_step(fa[1:0], fb[0]);
          "U":     uart_frame_check(fa[7:0]);
          "H":     hex_check(fa[1:0], fb[6:0]);
          default: begin
            errors++;
            $display("Unknown operation %0s in test %0s", op, name);
          end
        endcase
        next_record(ok);
      end
      $fclose(fd);
    end

    assert_fails = soc_top_i.chk_i.fails;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== tests/soc_top_tests.txt ====
# Columns: op name field_a field_b, fields in hex
# W addr data | R addr expected | Q quad pb | U byte 0 | H digit segments
H hex_reset 0 40
W ram_wr0 0000 1234
W ram_wr1 0002 abcd
W ram_wr2 01fe 5a5a
R ram_rd0 0000 1234
R ram_rd1 0002 abcd
R ram_rd2 01fe 5a5a
R unmapped 4000 0000
W uart_wr 8000 00a5
R uart_busy 8002 0001
W uart_wr_busy 8000 003c
U uart_frame a5 0
R uart_last 8000 00a5
R uart_idle 8002 0000
Q enc_fwd 1 0
R enc_cnt1 9000 0001
W enc_load23 9000 0017
Q enc_wrap_up 3 0
R enc_cnt_wrap 9000 0000
Q enc_wrap_dn 1 0
R enc_cnt_back 9000 0017
W enc_load10 9000 000a
R enc_cnt10 9000 000a
W enc_bad 9000 001e
R enc_keep 9000 000a
Q enc_pb 1 1
R enc_pb_rd 9002 0001
W hex_wr a000 1234
R hex_rd a000 1234
H hex_d0 0 19
H hex_d1 1 30
H hex_d3 3 79
W hex_wr2 a000 f6a9
H hex_e0 0 10
H hex_e3 3 0e

// ==== soc_top.f ====
design/soc_pkg.sv
design/periph_bus_if.sv
design/bus_decode.sv
design/scratch_ram.sv
design/uart_tx.sv
design/quad_encoder.sv
design/hex_display.sv
design/soc_top.sv
tests/soc_top_chk.sv
tests/soc_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run soc_top_tb with Verilator from the project root
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f soc_top.f \
  --top-module soc_top_tb -o soc_top_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/soc_top_sim +verilator+error+limit+100 > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
